//--- hw/lsu_pkg.sv
package lsu_pkg;

	// Integer register and data path width
	localparam int XLEN = 64;

	// Destination tag, 5 architectural bits plus 2 rename bits
	localparam int RD_TAG_W = 7;

	// Row address width of one DTCM bank
	// 1024 rows of 8 bytes per bank, 16 KiB over both banks
	localparam int DTCM_AW = 10;

	// First address bit of the bank row index
	// Bit 3 picks the bank, bits 2..0 are the byte offset
	localparam int ROW_SHIFT = 4;

	// Operations issued to the load/store unit
	typedef enum logic [3:0] {
		NOP     = 4'd0,
		LB      = 4'd1,
		LH      = 4'd2,
		LW      = 4'd3,
		LD      = 4'd4,
		LBU     = 4'd5,
		LHU     = 4'd6,
		LWU     = 4'd7,
		SB      = 4'd8,
		SH      = 4'd9,
		SW      = 4'd10,
		SD      = 4'd11,
		FENCE   = 4'd12,
		FENCE_I = 4'd13
	} lsu_op_e;

endpackage

//--- hw/lsu_issue.sv
module lsu_issue (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  logic                           exe_valid,
	input  lsu_pkg::lsu_op_e               exe_op,
	input  logic [lsu_pkg::RD_TAG_W-1:0]   exe_rd,
	input  logic [3:0]                     addr_lo,
	input  logic                           flush,
	output logic                           store_en,
	output lsu_pkg::lsu_op_e               ld_op,
	output logic [2:0]                     ld_ofs,
	output logic                           ld_odd,
	output logic                           wb_valid,
	output logic [lsu_pkg::RD_TAG_W-1:0]   wb_rd
);

	import lsu_pkg::*;

	// Slot is live when valid and not flushed in the same cycle
	logic live;
	logic is_load;
	logic is_store;
	lsu_op_e ld_op_d;

	assign live = exe_valid & ~flush;

	// Opcode classes
	assign is_store = exe_op inside {SB, SH, SW, SD};
	assign is_load  = exe_op inside {LB, LH, LW, LD, LBU, LHU, LWU};

	// Only place where the opcode meets valid and flush
	assign store_en = live & is_store;

	// Load function for the next cycle
	// Stores, fences, dead slots all become NOP so the result reads zero
	assign ld_op_d = (live && is_load) ? exe_op : NOP;

	// Control state of the writeback stage
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ld_op    <= NOP;
			wb_valid <= 1'b0;
		end else begin
			ld_op    <= ld_op_d;
			// Every live slot writes back, fences and stores included
			wb_valid <= live;
		end
	end

	// Payload of the writeback stage
	always_ff @(posedge CLK) begin
		// Byte offset inside the doubleword
		ld_ofs <= addr_lo[2:0];
		// Odd doubleword, bank B holds the low half of the window
		ld_odd <= addr_lo[3];
		wb_rd  <= exe_rd;
	end

endmodule

//--- hw/lsu_store_align.sv
module lsu_store_align (
	input  lsu_pkg::lsu_op_e              exe_op,
	input  logic [lsu_pkg::XLEN-1:0]      exe_op1,
	input  logic [lsu_pkg::XLEN-1:0]      exe_op2,
	output logic [lsu_pkg::DTCM_AW-1:0]   addr_a,
	output logic [lsu_pkg::DTCM_AW-1:0]   addr_b,
	output logic [lsu_pkg::XLEN-1:0]      wdata_a,
	output logic [lsu_pkg::XLEN-1:0]      wdata_b,
	output logic [7:0]                    wmask_a,
	output logic [7:0]                    wmask_b
);

	import lsu_pkg::*;

	logic [DTCM_AW-1:0] row;
	logic               dw_odd;
	logic [2:0]         ofs;
	logic [15:0]        base_mask;
	logic [15:0]        win_mask;
	logic [2*XLEN-1:0]  win_data;

	// Address fields
	assign row    = exe_op1[ROW_SHIFT +: DTCM_AW];
	assign dw_odd = exe_op1[ROW_SHIFT-1];
	assign ofs    = exe_op1[2:0];

	// Odd doubleword spills into bank A of the next row
	assign addr_a = row + {{(DTCM_AW-1){1'b0}}, dw_odd};
	// Bank B always sits in the addressed row
	assign addr_b = row;

	// Access width as a byte mask, loads and fences write nothing
	always_comb begin
		case (exe_op)
			SB:      base_mask = 16'h0001;
			SH:      base_mask = 16'h0003;
			SW:      base_mask = 16'h000f;
			SD:      base_mask = 16'h00ff;
			default: base_mask = 16'h0000;
		endcase
	end

	// Place mask and data at the byte offset in a 16-byte window
	assign win_mask = base_mask << ofs;
	assign win_data = {{XLEN{1'b0}}, exe_op2} << {ofs, 3'b000};

	// Low half of the window goes to bank B for odd doublewords
	assign wmask_a = dw_odd ? win_mask[15:8] : win_mask[7:0];
	assign wmask_b = dw_odd ? win_mask[7:0]  : win_mask[15:8];
	assign wdata_a = dw_odd ? win_data[2*XLEN-1:XLEN] : win_data[XLEN-1:0];
	assign wdata_b = dw_odd ? win_data[XLEN-1:0]      : win_data[2*XLEN-1:XLEN];

endmodule

//--- hw/dtcm_bank.sv
module dtcm_bank #(
	parameter int AW = 10
) (
	input  logic                       CLK,
	input  logic                       rst_n,
	input  logic [AW-1:0]              addr,
	input  logic [lsu_pkg::XLEN-1:0]   wdata,
	input  logic                       wen,
	input  logic [7:0]                 wmask,
	output logic [lsu_pkg::XLEN-1:0]   rdata
);

	import lsu_pkg::*;

	localparam int DEPTH = 1 << AW;

	// One doubleword per row
	logic [XLEN-1:0] mem [DEPTH];

	// Byte lane writes
	always_ff @(posedge CLK) begin
		if (wen) begin
			for (int i = 0; i < 8; i++) begin
				if (wmask[i]) begin
					mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

	// Registered read
	// Same-row write in this cycle is not visible yet, old data comes out
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

//--- hw/lsu_load_align.sv
module lsu_load_align (
	input  lsu_pkg::lsu_op_e           ld_op,
	input  logic [2:0]                 ld_ofs,
	input  logic                       ld_odd,
	input  logic [lsu_pkg::XLEN-1:0]   rdata_a,
	input  logic [lsu_pkg::XLEN-1:0]   rdata_b,
	output logic [lsu_pkg::XLEN-1:0]   wb_res
);

	import lsu_pkg::*;

	logic [2*XLEN-1:0] window;
	logic [2*XLEN-1:0] shifted;
	logic [7:0]        ld_b;
	logic [15:0]       ld_h;
	logic [31:0]       ld_w;
	logic [XLEN-1:0]   ld_d;

	// Addressed doubleword in the low half, next one above it
	assign window = ld_odd ? {rdata_a, rdata_b} : {rdata_b, rdata_a};

	// Bring the first addressed byte down to bit 0
	assign shifted = window >> {ld_ofs, 3'b000};

	// Candidate fields of each width
	assign ld_b = shifted[7:0];
	assign ld_h = shifted[15:0];
	assign ld_w = shifted[31:0];
	assign ld_d = shifted[XLEN-1:0];

	// Extension by opcode
	// NOP covers stores, fences and idle cycles
	always_comb begin
		case (ld_op)
			LB:      wb_res = {{(XLEN-8){ld_b[7]}}, ld_b};
			LH:      wb_res = {{(XLEN-16){ld_h[15]}}, ld_h};
			LW:      wb_res = {{(XLEN-32){ld_w[31]}}, ld_w};
			LD:      wb_res = ld_d;
			LBU:     wb_res = {{(XLEN-8){1'b0}}, ld_b};
			LHU:     wb_res = {{(XLEN-16){1'b0}}, ld_h};
			LWU:     wb_res = {{(XLEN-32){1'b0}}, ld_w};
			default: wb_res = '0;
		endcase
	end

endmodule

//--- hw/lsu_top.sv
module lsu_top (
	input  logic                           CLK,
	input  logic                           rst_n,
	input  logic                           exe_valid,
	input  lsu_pkg::lsu_op_e               exe_op,
	input  logic [lsu_pkg::RD_TAG_W-1:0]   exe_rd,
	input  logic [lsu_pkg::XLEN-1:0]       exe_op1,
	input  logic [lsu_pkg::XLEN-1:0]       exe_op2,
	input  logic                           flush,
	output logic                           wb_valid,
	output logic [lsu_pkg::XLEN-1:0]       wb_res,
	output logic [lsu_pkg::RD_TAG_W-1:0]   wb_rd
);

	import lsu_pkg::*;

	// Issue to load path
	logic       store_en;
	lsu_op_e    ld_op;
	logic [2:0] ld_ofs;
	logic       ld_odd;

	// Bank A, even doublewords
	logic [DTCM_AW-1:0] addr_a;
	logic [XLEN-1:0]    wdata_a;
	logic [7:0]         wmask_a;
	logic [XLEN-1:0]    rdata_a;

	// Bank B, odd doublewords
	logic [DTCM_AW-1:0] addr_b;
	logic [XLEN-1:0]    wdata_b;
	logic [7:0]         wmask_b;
	logic [XLEN-1:0]    rdata_b;

	// Decode, flush gating, writeback stage
	lsu_issue i_issue (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.exe_valid (exe_valid),
		.exe_op    (exe_op),
		.exe_rd    (exe_rd),
		.addr_lo   (exe_op1[3:0]),
		.flush     (flush),
		.store_en  (store_en),
		.ld_op     (ld_op),
		.ld_ofs    (ld_ofs),
		.ld_odd    (ld_odd),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd)
	);

	// Bank addresses and write lanes in the accept cycle
	lsu_store_align i_store_align (
		.exe_op  (exe_op),
		.exe_op1 (exe_op1),
		.exe_op2 (exe_op2),
		.addr_a  (addr_a),
		.addr_b  (addr_b),
		.wdata_a (wdata_a),
		.wdata_b (wdata_b),
		.wmask_a (wmask_a),
		.wmask_b (wmask_b)
	);

	// Both banks share the store enable, masks pick the lanes
	dtcm_bank #(
		.AW (DTCM_AW)
	) i_bank_a (
		.CLK   (CLK),
		.rst_n (rst_n),
		.addr  (addr_a),
		.wdata (wdata_a),
		.wen   (store_en),
		.wmask (wmask_a),
		.rdata (rdata_a)
	);

	dtcm_bank #(
		.AW (DTCM_AW)
	) i_bank_b (
		.CLK   (CLK),
		.rst_n (rst_n),
		.addr  (addr_b),
		.wdata (wdata_b),
		.wen   (store_en),
		.wmask (wmask_b),
		.rdata (rdata_b)
	);

	// Result formed from bank outputs in the writeback cycle
	lsu_load_align i_load_align (
		.ld_op   (ld_op),
		.ld_ofs  (ld_ofs),
		.ld_odd  (ld_odd),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b),
		.wb_res  (wb_res)
	);

endmodule

//--- sim/tb_clkgen.sv
module tb_clkgen (
	output logic CLK,
	output logic rst_n
);

	// 10 unit period, first rising edge at 5
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Low over the first 4 rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (4) @(negedge CLK);
		rst_n = 1'b1;
	end

endmodule

//--- sim/tb_top.sv
module tb_top;

	import lsu_pkg::*;

	// Both banks, 8 bytes per row
	localparam int MEM_BYTES  = 2 * 8 * (1 << DTCM_AW);
	localparam int WB_TIMEOUT = 8;

	logic                CLK;
	logic                rst_n;
	logic                exe_valid;
	lsu_op_e             exe_op;
	logic [RD_TAG_W-1:0] exe_rd;
	logic [XLEN-1:0]     exe_op1;
	logic [XLEN-1:0]     exe_op2;
	logic                flush;
	logic                wb_valid;
	logic [XLEN-1:0]     wb_res;
	logic [RD_TAG_W-1:0] wb_rd;

	// Reference image of the DTCM, plain byte order
	logic [7:0] ref_mem [MEM_BYTES];

	int                  errors;
	int                  timeouts;
	int                  seed;
	logic [RD_TAG_W-1:0] next_tag;

	tb_clkgen i_clkgen (
		.CLK   (CLK),
		.rst_n (rst_n)
	);

	lsu_top i_dut (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.exe_valid (exe_valid),
		.exe_op    (exe_op),
		.exe_rd    (exe_rd),
		.exe_op1   (exe_op1),
		.exe_op2   (exe_op2),
		.flush     (flush),
		.wb_valid  (wb_valid),
		.wb_res    (wb_res),
		.wb_rd     (wb_rd)
	);

	// Access size in bytes, zero for fences
	function automatic int op_bytes(lsu_op_e op);
		case (op)
			LB, LBU, SB: return 1;
			LH, LHU, SH: return 2;
			LW, LWU, SW: return 4;
			LD, SD:      return 8;
			default:     return 0;
		endcase
	endfunction

	function automatic bit reads_memory(lsu_op_e op);
		return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
	endfunction

	function automatic bit writes_memory(lsu_op_e op);
		return op inside {SB, SH, SW, SD};
	endfunction

	function automatic logic [XLEN-1:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// Little-endian store into the reference image
	function automatic void mem_write(lsu_op_e op, int addr, logic [XLEN-1:0] data);
		for (int i = 0; i < op_bytes(op); i++) begin
			ref_mem[addr + i] = data[i*8 +: 8];
		end
	endfunction

	// Load result by the extension rule
	function automatic logic [XLEN-1:0] expected_load(lsu_op_e op, int addr);
		logic [XLEN-1:0] raw;
		int              n;
		logic            sign;
		raw = '0;
		n = op_bytes(op);
		for (int i = 0; i < n; i++) begin
			raw[i*8 +: 8] = ref_mem[addr + i];
		end
		// Signed forms copy the top loaded bit upward, LD has nothing to extend
		if (op inside {LB, LH, LW}) begin
			sign = raw[n*8-1];
			for (int i = n*8; i < XLEN; i++) begin
				raw[i] = sign;
			end
		end
		return raw;
	endfunction

	task automatic check_value(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Called at a falling edge, accepted at the next rising one
	task automatic drive_op(lsu_op_e op, logic [RD_TAG_W-1:0] tag, int addr,
			logic [XLEN-1:0] data, logic fl);
		exe_valid = 1'b1;
		exe_op    = op;
		exe_rd    = tag;
		exe_op1   = {32'h0, addr};
		exe_op2   = data;
		flush     = fl;
		next_tag  = next_tag + RD_TAG_W'(1);
	endtask

	task automatic go_idle();
		exe_valid = 1'b0;
		exe_op    = NOP;
		exe_rd    = '0;
		exe_op1   = '0;
		exe_op2   = '0;
		flush     = 1'b0;
	endtask

	// Entered one falling edge after issue, so a ready writeback means latency 1
	task automatic collect_wb(logic [RD_TAG_W-1:0] tag, logic [XLEN-1:0] exp_res);
		int cycles;
		cycles = 1;
		while (!wb_valid && cycles < WB_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!wb_valid) begin
			errors++;
			timeouts++;
			$display("Timeout at %0t, no writeback seen for tag %0d", $time, tag);
		end else begin
			check_value("wb_valid latency", XLEN'(cycles), XLEN'(1));
			check_value("wb_rd", XLEN'(wb_rd), XLEN'(tag));
			check_value("wb_res", wb_res, exp_res);
		end
	endtask

	// wb_valid must stay low, first look is one cycle after the issue
	task automatic expect_no_wb(int cycles);
		for (int i = 0; i < cycles; i++) begin
			check_value("wb_valid", XLEN'(wb_valid), '0);
			@(negedge CLK);
		end
	endtask

	// One instruction alone in the pipe
	task automatic run_op(lsu_op_e op, int addr, logic [XLEN-1:0] data);
		logic [RD_TAG_W-1:0] tag;
		logic [XLEN-1:0]     exp_res;
		tag = next_tag;
		exp_res = reads_memory(op) ? expected_load(op, addr) : '0;
		drive_op(op, tag, addr, data, 1'b0);
		if (writes_memory(op)) begin
			mem_write(op, addr, data);
		end
		@(negedge CLK);
		go_idle();
		collect_wb(tag, exp_res);
	endtask

	// Two instructions on consecutive cycles
	task automatic pair_ops(lsu_op_e op1, int addr1, logic [XLEN-1:0] data1,
			lsu_op_e op2, int addr2, logic [XLEN-1:0] data2);
		logic [RD_TAG_W-1:0] tag1;
		logic [RD_TAG_W-1:0] tag2;
		logic [XLEN-1:0]     exp1;
		logic [XLEN-1:0]     exp2;
		tag1 = next_tag;
		exp1 = reads_memory(op1) ? expected_load(op1, addr1) : '0;
		drive_op(op1, tag1, addr1, data1, 1'b0);
		if (writes_memory(op1)) begin
			mem_write(op1, addr1, data1);
		end
		@(negedge CLK);
		// Second result must already see the first store
		tag2 = next_tag;
		exp2 = reads_memory(op2) ? expected_load(op2, addr2) : '0;
		drive_op(op2, tag2, addr2, data2, 1'b0);
		if (writes_memory(op2)) begin
			mem_write(op2, addr2, data2);
		end
		collect_wb(tag1, exp1);
		@(negedge CLK);
		go_idle();
		collect_wb(tag2, exp2);
	endtask

	task automatic check_reset_idle();
		for (int i = 0; i < 6; i++) begin
			@(negedge CLK);
			check_value("wb_valid", XLEN'(wb_valid), '0);
			check_value("wb_res", wb_res, '0);
		end
	endtask

	// Known contents everywhere, pattern from the full byte address
	task automatic fill_memory();
		logic [XLEN-1:0] pattern;
		for (int a = 0; a < MEM_BYTES; a += 8) begin
			pattern = {16'hc3a5, a[15:0], ~a[15:0], a[15:0] ^ 16'h5a3c};
			run_op(SD, a, pattern);
		end
	endtask

	task automatic aligned_round_trip();
		lsu_op_e st_ops [4] = '{SB, SH, SW, SD};
		lsu_op_e ld_ops [7] = '{LB, LH, LW, LD, LBU, LHU, LWU};
		int      addr;
		for (int w = 0; w < 4; w++) begin
			// b selects bank A or bank B
			for (int b = 0; b < 2; b++) begin
				addr = 256 + 64*w + 8*b;
				run_op(st_ops[w], addr, rand64());
				for (int k = 0; k < 7; k++) begin
					run_op(ld_ops[k], addr, '0);
				end
			end
		end
	endtask

	task automatic sign_zero_extension();
		lsu_op_e ext_ops [6] = '{LB, LBU, LH, LHU, LW, LWU};
		int      step;
		// Every byte negative in bank A, mixed signs in bank B
		run_op(SD, 1024, 64'h8081_f0ff_9abc_defe);
		run_op(SD, 1032, 64'h7f80_017f_ff00_8000);
		for (int k = 0; k < 6; k++) begin
			step = op_bytes(ext_ops[k]);
			for (int o = 0; o < 16; o += step) begin
				run_op(ext_ops[k], 1024 + o, '0);
			end
		end
	endtask

	task automatic misaligned_access();
		int base;
		for (int ofs = 1; ofs < 8; ofs++) begin
			base = 4096 + 64*ofs;
			run_op(SD, base + ofs, rand64());
			// Bank B into bank A of the next row
			run_op(SD, base + 8 + ofs, rand64());
			run_op(SW, base + 32 + ofs, rand64());
			run_op(SW, base + 40 + ofs, rand64());
			// Aligned sweep covers the neighbouring bytes
			for (int k = 0; k < 8; k++) begin
				run_op(LD, base + 8*k, '0);
			end
			run_op(LD, base + 7 + ofs, '0);
			run_op(LW, base + 39 + ofs, '0);
			run_op(LHU, base + 15, '0);
			run_op(LB, base + 47, '0);
		end
	endtask

	task automatic back_to_back();
		int addr;
		for (int i = 0; i < 4; i++) begin
			addr = 8192 + 25*i;
			pair_ops(SD, addr, rand64(), LD, addr, '0);
			pair_ops(SW, addr + 3, rand64(), LBU, addr + 5, '0);
			pair_ops(SB, addr + 7, rand64(), LH, addr + 7, '0);
		end
		// Non-loads back to back, zero results and own tags
		pair_ops(LD, 8192, '0, FENCE, 0, rand64());
		pair_ops(FENCE_I, 0, '0, SH, 8300, rand64());
		run_op(FENCE, 64, '0);
		run_op(FENCE_I, 128, '0);
		run_op(LWU, 8300, '0);
	endtask

	task automatic flush_cancel();
		int addr;
		addr = 12288 + 3;
		// Flushed store, memory keeps its old bytes
		drive_op(SD, next_tag, addr, rand64(), 1'b1);
		@(negedge CLK);
		go_idle();
		expect_no_wb(3);
		run_op(LD, addr, '0);
		run_op(LD, addr - 3, '0);
		run_op(LD, addr + 5, '0);
		// Flushed load
		drive_op(LD, next_tag, addr, '0, 1'b1);
		@(negedge CLK);
		go_idle();
		expect_no_wb(3);
		// Flushed byte store straight before a live load of that byte
		drive_op(SB, next_tag, addr, rand64(), 1'b1);
		@(negedge CLK);
		check_value("wb_valid", XLEN'(wb_valid), '0);
		run_op(LBU, addr, '0);
	endtask

	initial begin
		int n;
		errors   = 0;
		timeouts = 0;
		seed     = 46860;
		next_tag = '0;
		go_idle();

		n = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(negedge CLK);
			n++;
		end
		if (rst_n !== 1'b1) begin
			errors++;
			timeouts++;
			$display("Timeout waiting for reset to be released");
		end

		check_reset_idle();
		fill_memory();
		aligned_round_trip();
		sign_zero_extension();
		misaligned_access();
		back_to_back();
		flush_cancel();

		$display("Errors: %0d, of which timeouts: %0d", errors, timeouts);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- sources.f
hw/lsu_pkg.sv
hw/lsu_issue.sv
hw/lsu_store_align.sv
hw/dtcm_bank.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
sim/tb_clkgen.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --top-module tb_top -f sources.f -Mdir "$OBJ" -o vtb_top
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ/vtb_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
	exit 1
fi

exit 0
